// ==== build.f ====
logic/GpioPkg.sv
logic/GpioRegs.sv
logic/DutyGenerator.sv
logic/LedDriver.sv
logic/GpioTop.sv
verif/GpioTb.sv

// ==== Bender.yml ====
package:
  name: gpio_led_ctrl

sources:
  - logic/GpioPkg.sv
  - logic/GpioRegs.sv
  - logic/DutyGenerator.sv
  - logic/LedDriver.sv
  - logic/GpioTop.sv
  - target: test
    files:
      - verif/GpioTb.sv

// ==== verif/GpioTb.sv ====
//----------------------------------------------------------------------
// GPIO LED controller testbench
// Drives the AXI4-Lite bus and checks register access and the steady,
// blink and PWM behavior at the LED pins
//----------------------------------------------------------------------
`timescale 1ns/1ps

module GpioTb;
	import GpioPkg::*;

	localparam int lpWaitLimit = 100;
	// Off level per pin, RGB pins are active low
	localparam logic [4:0] lpPinsOff = 5'b11100;

	logic        iSysClk;
	logic        reset;
	AxiLiteReq   axiReq;
	AxiLiteRsp   axiRsp;
	logic [1:0]  led;
	logic        ledR;
	logic        ledG;
	logic        ledB;

	int          errorCount = 0;
	int          checkCount = 0;
	int          timeoutCount = 0;
	logic [31:0] lcgState = 32'd75499;

	GpioTop uut (
		.iSysClk (iSysClk),
		.reset   (reset),
		.axiReq  (axiReq),
		.axiRsp  (axiRsp),
		.led     (led),
		.ledR    (ledR),
		.ledG    (ledG),
		.ledB    (ledB)
	);

	always #2 iSysClk = ~iSysClk;

	//------------------------------------------------------------------
	// Bus protocol properties
	//------------------------------------------------------------------
	assert property (@(posedge iSysClk) disable iff (reset)
		axiRsp.bvalid && !axiReq.bready |=> axiRsp.bvalid)
	else
	begin
		errorCount++;
		$display("Write response dropped while bready was low");
	end

	assert property (@(posedge iSysClk) disable iff (reset)
		axiRsp.rvalid && !axiReq.rready |=> axiRsp.rvalid && $stable(axiRsp.rdata))
	else
	begin
		errorCount++;
		$display("Read response dropped or changed while rready was low");
	end

	assert property (@(posedge iSysClk) axiRsp.awready == axiRsp.wready)
	else
	begin
		errorCount++;
		$display("awready and wready disagree");
	end

	//------------------------------------------------------------------
	// Helpers
	//------------------------------------------------------------------
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState ^ (lcgState >> 16);
	endfunction

	// Bits of each register that hold a field
	function automatic logic [31:0] fieldMask(input logic [7:0] addr);
		if (addr == 8'h00)
			return 32'h1F;
		if (addr == 8'h04)
			return 32'h3;
		if (addr >= 8'h08 && addr <= 8'h18)
			return 32'hFF;
		if (addr >= 8'h1C && addr <= 8'h2C)
			return 32'hFFFF;
		return 32'h0;
	endfunction

	function automatic logic [4:0] pinState();
		return {ledB, ledG, ledR, led};
	endfunction

	task automatic finishRun();
		$display("Checks: %0d, errors: %0d, timeouts: %0d", checkCount, errorCount,
			timeoutCount);
		if (errorCount == 0 && timeoutCount == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	endtask

	task automatic guardWait(input int waited, input string what);
		if (waited >= lpWaitLimit)
		begin
			timeoutCount++;
			$display("Timeout: no %s after %0d cycles", what, waited);
		end
	endtask

	// Ends the run as soon as any wait gives up
	initial
	begin
		wait (timeoutCount > 0);
		finishRun();
	end

	task automatic checkValue(input string testName, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (expected === actual)
		else
		begin
			errorCount++;
			$display("ERROR %s: expected 0x%0h, actual 0x%0h", testName, expected, actual);
		end
	endtask

	//------------------------------------------------------------------
	// AXI4-Lite master
	//------------------------------------------------------------------
	// bready stays low for holdCycles after bvalid rises
	task automatic axiWrite(input logic [7:0] addr, input logic [31:0] data,
		input logic [3:0] strb, input int holdCycles, output logic [1:0] resp);
		int waited;
		@(posedge iSysClk);
		axiReq.awaddr  <= addr;
		axiReq.awvalid <= 1'b1;
		axiReq.wdata   <= data;
		axiReq.wstrb   <= strb;
		axiReq.wvalid  <= 1'b1;
		axiReq.bready  <= (holdCycles == 0);
		waited = 0;
		@(negedge iSysClk);
		while (!axiRsp.awready)
		begin
			guardWait(waited, "write accept");
			waited++;
			@(negedge iSysClk);
		end
		@(posedge iSysClk);
		axiReq.awvalid <= 1'b0;
		axiReq.wvalid  <= 1'b0;
		waited = 0;
		@(negedge iSysClk);
		while (!axiRsp.bvalid)
		begin
			guardWait(waited, "write response");
			waited++;
			@(negedge iSysClk);
		end
		resp = axiRsp.bresp;
		if (holdCycles > 0)
		begin
			repeat (holdCycles)
			begin
				@(negedge iSysClk);
				checkValue("bvalid held", 1, axiRsp.bvalid);
			end
			@(posedge iSysClk);
			axiReq.bready <= 1'b1;
			waited = 0;
			@(negedge iSysClk);
			while (axiRsp.bvalid)
			begin
				guardWait(waited, "release of the write response");
				waited++;
				@(negedge iSysClk);
			end
		end
	endtask

	// rready stays low for holdCycles after rvalid rises
	task automatic axiRead(input logic [7:0] addr, input int holdCycles,
		output logic [31:0] data, output logic [1:0] resp);
		int waited;
		@(posedge iSysClk);
		axiReq.araddr  <= addr;
		axiReq.arvalid <= 1'b1;
		axiReq.rready  <= (holdCycles == 0);
		waited = 0;
		@(negedge iSysClk);
		while (!axiRsp.arready)
		begin
			guardWait(waited, "read accept");
			waited++;
			@(negedge iSysClk);
		end
		@(posedge iSysClk);
		axiReq.arvalid <= 1'b0;
		waited = 0;
		@(negedge iSysClk);
		while (!axiRsp.rvalid)
		begin
			guardWait(waited, "read response");
			waited++;
			@(negedge iSysClk);
		end
		data = axiRsp.rdata;
		resp = axiRsp.rresp;
		if (holdCycles > 0)
		begin
			repeat (holdCycles)
				@(negedge iSysClk);
			@(posedge iSysClk);
			axiReq.rready <= 1'b1;
			waited = 0;
			@(negedge iSysClk);
			while (axiRsp.rvalid)
			begin
				guardWait(waited, "release of the read response");
				waited++;
				@(negedge iSysClk);
			end
		end
	endtask

	//------------------------------------------------------------------
	// Tests
	//------------------------------------------------------------------
	task automatic verifyResetState();
		logic [31:0] data;
		logic [1:0]  resp;
		@(negedge iSysClk);
		checkValue("reset pins", lpPinsOff, pinState());
		checkValue("reset bvalid", 0, axiRsp.bvalid);
		checkValue("reset rvalid", 0, axiRsp.rvalid);
		for (int a = 0; a < 12; a++)
		begin
			axiRead(8'(4 * a), 0, data, resp);
			checkValue($sformatf("reset read 0x%02h", 4 * a), 0, data);
			checkValue($sformatf("reset resp 0x%02h", 4 * a), lpRespOkay, resp);
		end
	endtask

	task automatic registerAccess();
		logic [31:0] written [12];
		logic [31:0] data;
		logic [1:0]  resp;
		for (int a = 0; a < 12; a++)
		begin
			written[a] = nextRandom();
			axiWrite(8'(4 * a), written[a], 4'hF, 0, resp);
			checkValue($sformatf("write resp 0x%02h", 4 * a), lpRespOkay, resp);
		end
		for (int a = 0; a < 12; a++)
		begin
			axiRead(8'(4 * a), 0, data, resp);
			checkValue($sformatf("read back 0x%02h", 4 * a),
				written[a] & fieldMask(8'(4 * a)), data);
			checkValue($sformatf("read resp 0x%02h", 4 * a), lpRespOkay, resp);
		end
		// Only the low byte lane changes
		axiWrite(8'h1C, 32'h0000_ABCD, 4'hF, 0, resp);
		axiWrite(8'h1C, 32'h0000_0012, 4'h1, 0, resp);
		axiRead(8'h1C, 0, data, resp);
		checkValue("byte strobe", 32'hAB12, data);
		axiWrite(8'h40, 32'hFFFF_FFFF, 4'hF, 0, resp);
		checkValue("unmapped write resp", lpRespSlvErr, resp);
		axiRead(8'h40, 0, data, resp);
		checkValue("unmapped read data", 0, data);
		checkValue("unmapped read resp", lpRespSlvErr, resp);
		axiWrite(8'h04, 32'h0, 4'hF, 5, resp);
		checkValue("held write resp", lpRespOkay, resp);
		axiRead(8'h1C, 5, data, resp);
		checkValue("held read data", 32'hAB12, data);
		checkValue("held read resp", lpRespOkay, resp);
	endtask

	task automatic steadyAndModeThree();
		logic [4:0] en;
		logic [4:0] prevPins;
		logic [1:0] resp;
		axiWrite(8'h00, 32'h0, 4'hF, 0, resp);
		axiWrite(8'h04, 32'h0, 4'hF, 0, resp);
		for (int n = 0; n < 8; n++)
		begin
			// Second half runs with the unused mode code
			if (n == 4)
				axiWrite(8'h04, 32'h3, 4'hF, 0, resp);
			en = 5'(nextRandom());
			prevPins = pinState();
			axiWrite(8'h00, 32'(en), 4'hF, 0, resp);
			checkValue($sformatf("steady pins before update %0d", n), prevPins, pinState());
			@(negedge iSysClk);
			checkValue($sformatf("steady pins mode %0d", n / 4 * 3),
				{~en[4:2], en[1:0]}, pinState());
		end
	endtask

	task automatic blinkTiming();
		logic [4:0]  en;
		logic [15:0] interval [5];
		logic [4:0]  pins;
		logic [4:0]  lastPins;
		int          lastEdge [5];
		int          edges [5];
		logic [1:0]  resp;
		en = 5'b01101;
		axiWrite(8'h00, 32'h0, 4'hF, 0, resp);
		for (int ch = 0; ch < 5; ch++)
		begin
			interval[ch] = 16'(2 + nextRandom() % 10);
			axiWrite(8'(8'h1C + 4 * ch), 32'(interval[ch]), 4'hF, 0, resp);
			lastEdge[ch] = -1;
			edges[ch] = 0;
		end
		axiWrite(8'h04, 32'h1, 4'hF, 0, resp);
		axiWrite(8'h00, 32'(en), 4'hF, 0, resp);
		lastPins = pinState();
		for (int cyc = 0; cyc < 150; cyc++)
		begin
			@(negedge iSysClk);
			pins = pinState();
			for (int ch = 0; ch < 5; ch++)
			begin
				if (!en[ch])
					checkValue($sformatf("blink off ch%0d", ch), lpPinsOff[ch], pins[ch]);
				else if (pins[ch] != lastPins[ch])
				begin
					if (lastEdge[ch] >= 0)
						checkValue($sformatf("blink period ch%0d", ch), interval[ch] + 1,
							cyc - lastEdge[ch]);
					lastEdge[ch] = cyc;
					edges[ch]++;
				end
			end
			lastPins = pins;
		end
		for (int ch = 0; ch < 5; ch++)
		begin
			assert (!en[ch] || edges[ch] >= 3)
			else
			begin
				errorCount++;
				$display("Channel %0d did not blink", ch);
			end
		end
	endtask

	// Channel 3 gets duty 0 and channel 4 duty 255
	task automatic pwmDuty();
		logic [7:0] duty [5];
		logic [4:0] pins;
		int         onCount [5];
		logic [1:0] resp;
		axiWrite(8'h00, 32'h0, 4'hF, 0, resp);
		axiWrite(8'h04, 32'h2, 4'hF, 0, resp);
		for (int ch = 0; ch < 5; ch++)
		begin
			duty[ch] = (ch == 3) ? 8'd0 : (ch == 4) ? 8'd255 : 8'(1 + nextRandom() % 254);
			axiWrite(8'(8'h08 + 4 * ch), 32'(duty[ch]), 4'hF, 0, resp);
			onCount[ch] = 0;
		end
		axiWrite(8'h00, 32'h1F, 4'hF, 0, resp);
		@(negedge iSysClk);
		repeat (256)
		begin
			@(negedge iSysClk);
			pins = pinState() ^ lpPinsOff;
			for (int ch = 0; ch < 5; ch++)
				onCount[ch] += pins[ch];
		end
		for (int ch = 0; ch < 5; ch++)
			checkValue($sformatf("pwm on-cycles ch%0d", ch), duty[ch], onCount[ch]);
	endtask

	initial
	begin
		iSysClk = 1'b0;
		reset   = 1'b1;
		axiReq  = '0;
		repeat (16) @(posedge iSysClk);
		reset <= 1'b0;
		verifyResetState();
		registerAccess();
		steadyAndModeThree();
		blinkTiming();
		pwmDuty();
		finishRun();
	end

endmodule

// ==== logic/GpioTop.sv ====
//----------------------------------------------------------------------
// GPIO LED controller top level
// Register block, one duty generator per channel and the LED driver
//----------------------------------------------------------------------
`timescale 1ns/1ps

module GpioTop (
	input  logic               iSysClk,
	input  logic               reset,
	input  GpioPkg::AxiLiteReq axiReq,
	output GpioPkg::AxiLiteRsp axiRsp,
	output logic [1:0]         led,
	output logic               ledR,
	output logic               ledG,
	output logic               ledB
);
	import GpioPkg::*;

	GpioCfg                 cfg;
	logic [lpLedNumber-1:0] pwm;
	logic [lpLedNumber-1:0] tick;

	GpioRegs regs (
		.iSysClk (iSysClk),
		.reset   (reset),
		.axiReq  (axiReq),
		.axiRsp  (axiRsp),
		.cfg     (cfg)
	);

	//------------------------------------------------------------------
	// One timer pair per channel
	//------------------------------------------------------------------
	for (genvar ch = 0; ch < lpLedNumber; ch++)
	begin : genDuty
		DutyGenerator dutyGen (
			.iSysClk  (iSysClk),
			.reset    (reset),
			.enable   (cfg.enable[ch]),
			.duty     (cfg.duty[ch]),
			.interval (cfg.interval[ch]),
			.pwm      (pwm[ch]),
			.tick     (tick[ch])
		);
	end

	LedDriver driver (
		.iSysClk (iSysClk),
		.reset   (reset),
		.cfg     (cfg),
		.pwm     (pwm),
		.tick    (tick),
		.led     (led),
		.ledR    (ledR),
		.ledG    (ledG),
		.ledB    (ledB)
	);

endmodule

// ==== logic/LedDriver.sv ====
//----------------------------------------------------------------------
// LED driver
// Selects each channel's state by flash mode and applies pin polarity
// at the registered outputs
//----------------------------------------------------------------------
`timescale 1ns/1ps

module LedDriver (
	input  logic                            iSysClk,
	input  logic                            reset,
	input  GpioPkg::GpioCfg                 cfg,
	input  logic [GpioPkg::lpLedNumber-1:0] pwm,
	input  logic [GpioPkg::lpLedNumber-1:0] tick,
	output logic [1:0]                      led,
	output logic                            ledR,
	output logic                            ledG,
	output logic                            ledB
);
	import GpioPkg::*;

	// Logical state, 1 means lit regardless of pin polarity
	logic [lpLedNumber-1:0] ledOn;
	logic [lpLedNumber-1:0] ledOnNext;
	logic [lpLedNumber-1:0] pinLevel;

	//------------------------------------------------------------------
	// Next state per channel
	//------------------------------------------------------------------
	always_comb
	begin
		for (int i = 0; i < lpLedNumber; i++)
		begin
			case (cfg.mode)
				lpModeSteady:
					ledOnNext[i] = cfg.enable[i];
				lpModeBlink:
				begin
					// Hold between ticks so the LED actually blinks
					if (!cfg.enable[i])
						ledOnNext[i] = 1'b0;
					else if (tick[i])
						ledOnNext[i] = ~ledOn[i];
					else
						ledOnNext[i] = ledOn[i];
				end
				lpModePwm:
					ledOnNext[i] = cfg.enable[i] & pwm[i];
				default:
					// Unused code 3 behaves as steady
					ledOnNext[i] = cfg.enable[i];
			endcase
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			ledOn <= '0;
		else
			ledOn <= ledOnNext;
	end

	//------------------------------------------------------------------
	// Pin polarity, RGB pins are active low
	//------------------------------------------------------------------
	assign pinLevel = ledOn ^ lpLedActiveLow;

	assign led  = pinLevel[1:0];
	assign ledR = pinLevel[2];
	assign ledG = pinLevel[3];
	assign ledB = pinLevel[4];

endmodule

// ==== logic/DutyGenerator.sv ====
//----------------------------------------------------------------------
// Duty generator for one LED channel
// Free-running PWM counter against the duty and an interval timer
// producing a one-cycle blink tick
//----------------------------------------------------------------------
`timescale 1ns/1ps

module DutyGenerator (
	input  logic                                iSysClk,
	input  logic                                reset,
	input  logic                                enable,
	input  logic [GpioPkg::lpDutyWidth-1:0]     duty,
	input  logic [GpioPkg::lpIntervalWidth-1:0] interval,
	output logic                                pwm,
	output logic                                tick
);
	import GpioPkg::*;

	logic [lpDutyWidth-1:0]     pwmCount;
	logic [lpIntervalWidth-1:0] intervalCount;
	logic                       intervalEnd;

	//------------------------------------------------------------------
	// PWM counter, wraps every 2**lpDutyWidth cycles
	//------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
			pwmCount <= '0;
		else if (!enable)
			pwmCount <= '0;
		else
			pwmCount <= pwmCount + 1'b1;
	end

	// High for exactly duty counts per period
	assign pwm = enable & (pwmCount < duty);

	//------------------------------------------------------------------
	// Interval timer
	//------------------------------------------------------------------
	// Compare with >= so a shortened interval restarts at once
	assign intervalEnd = (intervalCount >= interval);

	always_ff @(posedge iSysClk)
	begin
		if (reset)
			intervalCount <= '0;
		else if (!enable)
			intervalCount <= '0;
		else if (intervalEnd)
			intervalCount <= '0;
		else
			intervalCount <= intervalCount + 1'b1;
	end

	// One pulse every interval+1 cycles
	assign tick = enable & intervalEnd;

endmodule

// ==== logic/GpioRegs.sv ====
//----------------------------------------------------------------------
// GPIO register block
// AXI4-Lite slave holding enable, mode, duty and interval registers,
// drives the LED configuration continuously
//----------------------------------------------------------------------
`timescale 1ns/1ps

module GpioRegs (
	input  logic               iSysClk,
	input  logic               reset,
	input  GpioPkg::AxiLiteReq axiReq,
	output GpioPkg::AxiLiteRsp axiRsp,
	output GpioPkg::GpioCfg    cfg
);
	import GpioPkg::*;

	typedef struct packed {
		logic                   hit;
		logic [lpDataWidth-1:0] word;
	} RegLookup;

	// awready and wready always move together
	logic                   awReady;
	logic                   bValid;
	logic [1:0]             bResp;
	logic                   arReady;
	logic                   rValid;
	logic [1:0]             rResp;
	logic [lpDataWidth-1:0] rData;
	GpioCfg                 cfgReg;

	logic                   writeFire;
	logic                   readFire;
	RegLookup               writeLook;
	RegLookup               readLook;
	logic [lpDataWidth-1:0] writeData;

	//------------------------------------------------------------------
	// Address decode helpers
	//------------------------------------------------------------------
	function automatic logic [lpAddrWidth-1:0] dutyAddr(input int ch);
		return lpAddrWidth'(lpRegDutyBase + 4 * ch);
	endfunction

	function automatic logic [lpAddrWidth-1:0] intervalAddr(input int ch);
		return lpAddrWidth'(lpRegIntervalBase + 4 * ch);
	endfunction

	// Current register value at an offset, zero padded
	function automatic RegLookup regLookup(input logic [lpAddrWidth-1:0] addr,
		input GpioCfg c);
		RegLookup res;
		res.hit  = 1'b1;
		res.word = '0;
		if (addr == lpRegEnable)
			res.word[lpLedNumber-1:0] = c.enable;
		else if (addr == lpRegMode)
			res.word[lpModeWidth-1:0] = c.mode;
		else
		begin
			res.hit = 1'b0;
			for (int i = 0; i < lpLedNumber; i++)
			begin
				if (addr == dutyAddr(i))
				begin
					res.hit                   = 1'b1;
					res.word[lpDutyWidth-1:0] = c.duty[i];
				end
				if (addr == intervalAddr(i))
				begin
					res.hit                       = 1'b1;
					res.word[lpIntervalWidth-1:0] = c.interval[i];
				end
			end
		end
		return res;
	endfunction

	// Byte lanes without a strobe keep the old value
	function automatic logic [lpDataWidth-1:0] mergeStrobe(
		input logic [lpDataWidth-1:0]   cur,
		input logic [lpDataWidth-1:0]   data,
		input logic [lpDataWidth/8-1:0] strb);
		logic [lpDataWidth-1:0] res;
		res = cur;
		for (int b = 0; b < lpDataWidth / 8; b++)
		begin
			if (strb[b])
				res[8*b +: 8] = data[8*b +: 8];
		end
		return res;
	endfunction

	assign writeFire = awReady & axiReq.awvalid & axiReq.wvalid;
	assign readFire  = arReady & axiReq.arvalid;
	assign writeLook = regLookup(axiReq.awaddr, cfgReg);
	assign readLook  = regLookup(axiReq.araddr, cfgReg);
	assign writeData = mergeStrobe(writeLook.word, axiReq.wdata, axiReq.wstrb);

	//------------------------------------------------------------------
	// Write channel and register file
	//------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			awReady <= 1'b0;
			bValid  <= 1'b0;
			cfgReg  <= '0;
		end
		else
		begin
			// Accept only with address and data present, no response held
			awReady <= axiReq.awvalid & axiReq.wvalid & ~awReady & ~bValid;
			if (writeFire)
				bValid <= 1'b1;
			else if (axiReq.bready)
				bValid <= 1'b0;

			if (writeFire)
			begin
				if (axiReq.awaddr == lpRegEnable)
					cfgReg.enable <= writeData[lpLedNumber-1:0];
				if (axiReq.awaddr == lpRegMode)
					cfgReg.mode <= writeData[lpModeWidth-1:0];
				for (int i = 0; i < lpLedNumber; i++)
				begin
					if (axiReq.awaddr == dutyAddr(i))
						cfgReg.duty[i] <= writeData[lpDutyWidth-1:0];
					if (axiReq.awaddr == intervalAddr(i))
						cfgReg.interval[i] <= writeData[lpIntervalWidth-1:0];
				end
			end
		end
	end

	always_ff @(posedge iSysClk)
	begin
		if (writeFire)
			bResp <= writeLook.hit ? lpRespOkay : lpRespSlvErr;
	end

	//------------------------------------------------------------------
	// Read channel
	//------------------------------------------------------------------
	always_ff @(posedge iSysClk)
	begin
		if (reset)
		begin
			arReady <= 1'b0;
			rValid  <= 1'b0;
		end
		else
		begin
			arReady <= axiReq.arvalid & ~arReady & ~rValid;
			if (readFire)
				rValid <= 1'b1;
			else if (axiReq.rready)
				rValid <= 1'b0;
		end
	end

	// Unmapped offsets already read back as zero
	always_ff @(posedge iSysClk)
	begin
		if (readFire)
		begin
			rData <= readLook.word;
			rResp <= readLook.hit ? lpRespOkay : lpRespSlvErr;
		end
	end

	assign axiRsp.awready = awReady;
	assign axiRsp.wready  = awReady;
	assign axiRsp.bresp   = bResp;
	assign axiRsp.bvalid  = bValid;
	assign axiRsp.arready = arReady;
	assign axiRsp.rdata   = rData;
	assign axiRsp.rresp   = rResp;
	assign axiRsp.rvalid  = rValid;

	assign cfg = cfgReg;

endmodule

// ==== logic/GpioPkg.sv ====
//----------------------------------------------------------------------
// GPIO LED controller package
// Channel count, field widths, register map, mode codes and the
// configuration and AXI4-Lite bus structs
//----------------------------------------------------------------------
package GpioPkg;

	// Channels 0 and 1 are the board LEDs, 2 to 4 are red, green, blue
	localparam int lpLedNumber = 5;
	localparam logic [lpLedNumber-1:0] lpLedActiveLow = 5'b11100;

	localparam int lpDutyWidth     = 8;
	localparam int lpIntervalWidth = 16;
	localparam int lpModeWidth     = 2;

	// Flash modes, code 3 falls back to steady
	localparam logic [lpModeWidth-1:0] lpModeSteady = 2'd0;
	localparam logic [lpModeWidth-1:0] lpModeBlink  = 2'd1;
	localparam logic [lpModeWidth-1:0] lpModePwm    = 2'd2;

	localparam int lpAddrWidth = 8;
	localparam int lpDataWidth = 32;

	// Register byte offsets
	localparam logic [lpAddrWidth-1:0] lpRegEnable       = 8'h00;
	localparam logic [lpAddrWidth-1:0] lpRegMode         = 8'h04;
	localparam logic [lpAddrWidth-1:0] lpRegDutyBase     = 8'h08;
	localparam logic [lpAddrWidth-1:0] lpRegIntervalBase = 8'h1C;

	localparam logic [1:0] lpRespOkay   = 2'b00;
	localparam logic [1:0] lpRespSlvErr = 2'b10;

	typedef struct packed {
		logic [lpLedNumber-1:0]                          enable;
		logic [lpModeWidth-1:0]                          mode;
		logic [lpLedNumber-1:0][lpDutyWidth-1:0]         duty;
		logic [lpLedNumber-1:0][lpIntervalWidth-1:0]     interval;
	} GpioCfg;

	// Master side of the bus
	typedef struct packed {
		logic [lpAddrWidth-1:0]   awaddr;
		logic                     awvalid;
		logic [lpDataWidth-1:0]   wdata;
		logic [lpDataWidth/8-1:0] wstrb;
		logic                     wvalid;
		logic                     bready;
		logic [lpAddrWidth-1:0]   araddr;
		logic                     arvalid;
		logic                     rready;
	} AxiLiteReq;

	// Slave side of the bus
	typedef struct packed {
		logic                   awready;
		logic                   wready;
		logic [1:0]             bresp;
		logic                   bvalid;
		logic                   arready;
		logic [lpDataWidth-1:0] rdata;
		logic [1:0]             rresp;
		logic                   rvalid;
	} AxiLiteRsp;

endpackage
